// ==== arcade_input_pkg.sv ====
`default_nettype none

package arcade_input_pkg;

    // one completed scan code
    typedef struct packed {
        logic       toggle;    // flips per event
        logic       pressed;   // make = 1, break = 0
        logic       extended;  // code came after E0
        logic [7:0] code;
    } key_event_t;

    // player byte bits 7 to 0 are W/Y, Z/X, B, A, up, down, left, right
    typedef struct packed {
        logic       pause;
        logic [3:0] start;
        logic [3:0] coin;
        logic [7:0] p1;
        logic [7:0] p2;
        logic [7:0] p3;
        logic [7:0] p4;
    } arcade_ctrl_t;

    typedef struct packed {
        logic enable;       // decode on
        logic release_all;  // single cycle clear
    } map_cfg_t;

    // APB byte addresses
    localparam logic [11:0] REG_CTRL  = 12'h000;
    localparam logic [11:0] REG_SYS   = 12'h004;
    localparam logic [11:0] REG_P12   = 12'h008;
    localparam logic [11:0] REG_P34   = 12'h00C;
    localparam logic [11:0] REG_COINS = 12'h010;

    localparam int unsigned CTRL_ENABLE_BIT  = 0;
    localparam int unsigned CTRL_RELEASE_BIT = 1;

endpackage

`default_nettype wire

// ==== ps2_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_rx #(
    parameter int unsigned FILTER_LEN = 4
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       ps2_clk,
    input  wire logic       ps2_data,
    output logic [7:0]      rx_byte,
    output logic            rx_valid
);

    localparam int unsigned CNT_W = $clog2(FILTER_LEN + 1);

    logic [1:0]       clk_sync;   // two flop synchronizers
    logic [1:0]       data_sync;
    logic             clk_filt;   // debounced ps2 clock
    logic [CNT_W-1:0] filt_cnt;
    logic             clk_fall;   // one cycle per accepted falling edge

    logic [9:0]       shift;      // start, data, parity
    logic [3:0]       bit_cnt;
    logic [10:0]      idle_cnt;   // stall timer while mid-frame
    logic [10:0]      frame;
    logic             frame_ok;

    // line sync and clock debounce
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_filt  <= 1'b1;
            filt_cnt  <= '0;
            clk_fall  <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_fall  <= 1'b0;
            if (clk_sync[1] == clk_filt) begin
                filt_cnt <= '0;               // glitch gone, start over
            end else if (filt_cnt == CNT_W'(FILTER_LEN - 1)) begin
                clk_filt <= clk_sync[1];
                filt_cnt <= '0;
                clk_fall <= ~clk_sync[1];
            end else begin
                filt_cnt <= filt_cnt + 1'b1;
            end
        end
    end

    // stop bit is the live data sample on the eleventh edge
    assign frame    = {data_sync[1], shift};
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);  // odd parity

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd0 && data_sync[1]) begin
                    bit_cnt <= '0;            // no start bit, stay idle
                end else if (bit_cnt == 4'd10) begin
                    bit_cnt  <= '0;
                    rx_valid <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (bit_cnt != 4'd0) begin
                if (idle_cnt == '1) begin
                    bit_cnt  <= '0;           // keyboard stalled, drop frame
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_fall) begin
            shift <= {data_sync[1], shift[9:1]};  // lsb first
            if (bit_cnt == 4'd10) begin
                rx_byte <= frame[8:1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== ps2_scancode.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_scancode import arcade_input_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] rx_byte,
    input  wire logic       rx_valid,
    output key_event_t      key_event
);

    localparam logic [7:0] PREFIX_EXT = 8'hE0;
    localparam logic [7:0] PREFIX_BRK = 8'hF0;

    logic ext_seen;   // E0 before current code
    logic brk_seen;   // F0 before current code

    always_ff @(posedge clk) begin
        if (reset) begin
            ext_seen  <= 1'b0;
            brk_seen  <= 1'b0;
            key_event <= '0;
        end else if (rx_valid) begin
            case (rx_byte)
                PREFIX_EXT: begin
                    ext_seen <= 1'b1;
                end
                PREFIX_BRK: begin
                    brk_seen <= 1'b1;
                end
                default: begin
                    // complete code, hand out an event
                    key_event.toggle   <= ~key_event.toggle;
                    key_event.pressed  <= ~brk_seen;
                    key_event.extended <= ext_seen;
                    key_event.code     <= rx_byte;
                    ext_seen           <= 1'b0;
                    brk_seen           <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== arcade_key_map.sv ====
`timescale 1ns/100ps
`default_nettype none

module arcade_key_map import arcade_input_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire key_event_t key_event,
    input  wire map_cfg_t   map_cfg,
    output arcade_ctrl_t    controls
);

    logic       old_toggle;
    logic       new_event;
    logic       p;            // level to write
    logic [8:0] key;          // {extended, code}

    assign new_event = key_event.toggle != old_toggle;
    assign p         = key_event.pressed;
    assign key       = {key_event.extended, key_event.code};

    always_ff @(posedge clk) begin
        if (reset) begin
            old_toggle <= 1'b0;
            controls   <= '0;
        end else begin
            old_toggle <= key_event.toggle;  // events consumed even when disabled
            if (map_cfg.release_all) begin
                controls <= '0;
            end else if (new_event && map_cfg.enable) begin
                case (key)
                    9'h016: controls.start[0] <= p;  // 1
                    9'h01e: controls.start[1] <= p;  // 2
                    9'h026: controls.start[2] <= p;  // 3
                    9'h025: controls.start[3] <= p;  // 4

                    9'h02e: controls.coin[0]  <= p;  // 5
                    9'h036: controls.coin[1]  <= p;  // 6
                    9'h03d: controls.coin[2]  <= p;  // 7
                    9'h03e: controls.coin[3]  <= p;  // 8

                    9'h175: controls.p1[3]    <= p;  // up
                    9'h172: controls.p1[2]    <= p;  // down
                    9'h16b: controls.p1[1]    <= p;  // left
                    9'h174: controls.p1[0]    <= p;  // right
                    9'h014: controls.p1[4]    <= p;  // left ctrl
                    9'h011: controls.p1[5]    <= p;  // left alt
                    9'h029: controls.p1[6]    <= p;  // space
                    9'h012: controls.p1[7]    <= p;  // left shift

                    9'h02d: controls.p2[3]    <= p;  // r
                    9'h02b: controls.p2[2]    <= p;  // f
                    9'h023: controls.p2[1]    <= p;  // d
                    9'h034: controls.p2[0]    <= p;  // g
                    9'h01c: controls.p2[4]    <= p;  // a
                    9'h01b: controls.p2[5]    <= p;  // s
                    9'h015: controls.p2[6]    <= p;  // q
                    9'h01d: controls.p2[7]    <= p;  // w

                    9'h043: controls.p3[3]    <= p;  // i
                    9'h042: controls.p3[2]    <= p;  // k
                    9'h03b: controls.p3[1]    <= p;  // j
                    9'h04b: controls.p3[0]    <= p;  // l
                    9'h114: controls.p3[4]    <= p;  // right ctrl
                    9'h059: controls.p3[5]    <= p;  // right shift
                    9'h05a: controls.p3[6]    <= p;  // enter

                    9'h075: controls.p4[3]    <= p;  // keypad 8
                    9'h072: controls.p4[2]    <= p;  // keypad 2
                    9'h06b: controls.p4[1]    <= p;  // keypad 4
                    9'h074: controls.p4[0]    <= p;  // keypad 6
                    9'h070: controls.p4[4]    <= p;  // keypad 0
                    9'h071: controls.p4[5]    <= p;  // keypad dot
                    9'h15a: controls.p4[6]    <= p;  // keypad enter

                    9'h04d: controls.pause    <= p;  // p
                    default: ;                       // unmapped key
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== arcade_input_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module arcade_input_regs import arcade_input_pkg::*; (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic         psel,
    input  wire logic         penable,
    input  wire logic         pwrite,
    input  wire logic [11:0]  paddr,
    input  wire logic [31:0]  pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    input  wire arcade_ctrl_t controls,
    output map_cfg_t          map_cfg
);

    logic        access;       // apb access phase
    logic        addr_ok;
    logic        addr_ro;      // read-only target
    logic        wr_en;
    logic        enable_q;
    logic        release_q;
    logic [3:0]  coin_prev;
    logic [3:0]  coin_rise;
    logic [2:0]  coin_rises;   // 0..4 new presses
    logic [16:0] coin_sum;
    logic [15:0] coin_count;

    assign access = psel & penable;
    assign pready = 1'b1;

    always_comb begin
        addr_ok = 1'b1;
        addr_ro = 1'b0;
        prdata  = '0;
        case (paddr)
            REG_CTRL:  prdata = {31'd0, enable_q};  // release bit reads 0
            REG_SYS: begin
                addr_ro = 1'b1;
                prdata  = {23'd0, controls.pause, controls.start, controls.coin};
            end
            REG_P12: begin
                addr_ro = 1'b1;
                prdata  = {16'd0, controls.p2, controls.p1};
            end
            REG_P34: begin
                addr_ro = 1'b1;
                prdata  = {16'd0, controls.p4, controls.p3};
            end
            REG_COINS: prdata = {16'd0, coin_count};
            default:   addr_ok = 1'b0;
        endcase
    end

    assign pslverr = access & (~addr_ok | (pwrite & addr_ro));
    assign wr_en   = access & pwrite & ~pslverr;

    // rising coin bits counted with saturation at all ones
    assign coin_rise  = controls.coin & ~coin_prev;
    assign coin_rises = 3'(coin_rise[0]) + 3'(coin_rise[1]) +
                        3'(coin_rise[2]) + 3'(coin_rise[3]);
    assign coin_sum   = {1'b0, coin_count} + 17'(coin_rises);

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_q   <= 1'b1;
            release_q  <= 1'b0;
            coin_prev  <= '0;
            coin_count <= '0;
        end else begin
            coin_prev <= controls.coin;
            release_q <= 1'b0;
            if (wr_en && paddr == REG_CTRL) begin
                enable_q  <= pwdata[CTRL_ENABLE_BIT];
                release_q <= pwdata[CTRL_RELEASE_BIT];
            end
            if (wr_en && paddr == REG_COINS) begin
                coin_count <= '0;                  // any write clears
            end else if (coin_sum[16]) begin
                coin_count <= '1;
            end else begin
                coin_count <= coin_sum[15:0];
            end
        end
    end

    assign map_cfg = '{enable: enable_q, release_all: release_q};

endmodule

`default_nettype wire

// ==== arcade_input.sv ====
`timescale 1ns/100ps
`default_nettype none

module arcade_input import arcade_input_pkg::*; #(
    parameter int unsigned FILTER_LEN = 4
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        ps2_clk,    // async, idle high
    input  wire logic        ps2_data,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [11:0] paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr
);

    logic [7:0]   rx_byte;
    logic         rx_valid;
    key_event_t   key_event;
    map_cfg_t     map_cfg;
    arcade_ctrl_t controls;

    ps2_rx #(
        .FILTER_LEN(FILTER_LEN)
    ) u_ps2_rx (
        .clk      (clk),
        .reset    (reset),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    ps2_scancode u_ps2_scancode (
        .clk       (clk),
        .reset     (reset),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .key_event (key_event)
    );

    arcade_key_map u_arcade_key_map (
        .clk       (clk),
        .reset     (reset),
        .key_event (key_event),
        .map_cfg   (map_cfg),
        .controls  (controls)
    );

    arcade_input_regs u_arcade_input_regs (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .controls (controls),
        .map_cfg  (map_cfg)
    );

endmodule

`default_nettype wire

// ==== arcade_input_tb_clk.sv ====
`timescale 1ns/100ps
`default_nettype none

module arcade_input_tb_clk #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;  // released on a rising edge
    end

endmodule

`default_nettype wire

// ==== arcade_input_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module arcade_input_assert import arcade_input_pkg::*; (
    input wire logic         clk,
    input wire logic         reset,
    input wire key_event_t   key_event,
    input wire map_cfg_t     map_cfg,
    input wire arcade_ctrl_t controls,
    input wire logic         pready
);

    int fail_count = 0;

    release_clears: assert property (@(posedge clk) disable iff (reset)
        map_cfg.release_all |=> controls == '0)
        else begin
            fail_count++;
            $error("controls not cleared one cycle after release_all");
        end

    // mapper only moves on a toggle change or a release
    controls_hold: assert property (@(posedge clk) disable iff (reset)
        !map_cfg.release_all && $stable(key_event.toggle) |=> $stable(controls))
        else begin
            fail_count++;
            $error("controls changed without a new key event");
        end

    pready_high: assert property (@(posedge clk) pready)
        else begin
            fail_count++;
            $error("pready was low");
        end

endmodule

bind arcade_input arcade_input_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .key_event (key_event),
    .map_cfg   (map_cfg),
    .controls  (controls),
    .pready    (pready)
);

`default_nettype wire

// ==== arcade_input_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module arcade_input_tb import arcade_input_pkg::*; ();

    localparam int NUM_KEYS   = 39;
    localparam int PS2_HALF   = 8;    // system cycles per ps2 clock phase
    localparam int FRAME_GAP  = 20;
    localparam int SETTLE     = 200;
    localparam int MAX_FRAMES = 800;  // bound over all five tests
    localparam int MAX_APB    = 420;
    localparam int WATCHDOG   = MAX_FRAMES * (11 * 2 * PS2_HALF + FRAME_GAP)
                              + (MAX_APB / 4) * SETTLE + MAX_APB * 2 + 10000;

    localparam logic [1:0] EV_KEY      = 2'd0;
    localparam logic [1:0] EV_RELEASE  = 2'd1;
    localparam logic [1:0] EV_ENABLE   = 2'd2;
    localparam logic [1:0] EV_COIN_CLR = 2'd3;

    // {bit position in arcade_ctrl_t, {extended, code}}
    localparam logic [14:0] KEY_TABLE [NUM_KEYS] = '{
        {6'd36, 9'h016}, {6'd37, 9'h01e}, {6'd38, 9'h026}, {6'd39, 9'h025},  // start
        {6'd32, 9'h02e}, {6'd33, 9'h036}, {6'd34, 9'h03d}, {6'd35, 9'h03e},  // coin
        {6'd27, 9'h175}, {6'd26, 9'h172}, {6'd25, 9'h16b}, {6'd24, 9'h174},  // p1
        {6'd28, 9'h014}, {6'd29, 9'h011}, {6'd30, 9'h029}, {6'd31, 9'h012},
        {6'd19, 9'h02d}, {6'd18, 9'h02b}, {6'd17, 9'h023}, {6'd16, 9'h034},  // p2
        {6'd20, 9'h01c}, {6'd21, 9'h01b}, {6'd22, 9'h015}, {6'd23, 9'h01d},
        {6'd11, 9'h043}, {6'd10, 9'h042}, {6'd9, 9'h03b}, {6'd8, 9'h04b},    // p3
        {6'd12, 9'h114}, {6'd13, 9'h059}, {6'd14, 9'h05a},
        {6'd3, 9'h075}, {6'd2, 9'h072}, {6'd1, 9'h06b}, {6'd0, 9'h074},      // p4
        {6'd4, 9'h070}, {6'd5, 9'h071}, {6'd6, 9'h15a},
        {6'd40, 9'h04d}                                                      // pause
    };

    logic        clk, reset, ps2_clk, ps2_data;
    logic        psel, penable, pwrite, pready, pslverr;
    logic [11:0] paddr;
    logic [31:0] pwdata, prdata;
    logic [31:0] rd_sys, rd_p12, rd_p34, rd_coins;  // last register snapshot
    logic [11:0] event_log [$];                     // {kind, level, key}
    string       test_name;
    int          errors = 0;
    event        check_req;
    event        check_done;

    arcade_input_tb_clk u_clk (.clk(clk), .reset(reset));

    arcade_input #(.FILTER_LEN(4)) dut (.*);

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // replays the logged events through the key table
    function automatic arcade_ctrl_t expected_controls(output int coin_edges);
        logic [40:0] ctrl;
        logic [3:0]  coin_before;
        logic        enabled;
        ctrl       = '0;
        enabled    = 1'b1;
        coin_edges = 0;
        foreach (event_log[i]) begin
            coin_before = ctrl[35:32];
            case (event_log[i][11:10])
                EV_KEY: begin
                    for (int k = 0; k < NUM_KEYS; k++) begin
                        if (enabled && KEY_TABLE[k][8:0] == event_log[i][8:0]) begin
                            ctrl[KEY_TABLE[k][14:9]] = event_log[i][9];
                        end
                    end
                end
                EV_RELEASE: ctrl = '0;
                EV_ENABLE:  enabled = event_log[i][9];
                default:    coin_edges = 0;  // counter cleared by a write
            endcase
            coin_edges += $countones(ctrl[35:32] & ~coin_before);
        end
        return arcade_ctrl_t'(ctrl);
    endfunction

    task automatic ps2_send(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};  // stop, odd parity, data, start
        for (int b = 0; b < 11; b++) begin
            @(posedge clk);
            ps2_data <= frame[b];
            repeat (PS2_HALF / 2) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (PS2_HALF) @(posedge clk);
            ps2_clk <= 1'b1;
            repeat (PS2_HALF / 2 - 1) @(posedge clk);
        end
        repeat (FRAME_GAP) @(posedge clk);
    endtask

    task automatic send_key(input logic [8:0] key, input logic pressed);
        if (key[8]) begin
            ps2_send(8'he0, 1'b0);
        end
        if (!pressed) begin
            ps2_send(8'hf0, 1'b0);
        end
        ps2_send(key[7:0], 1'b0);
        event_log.push_back({EV_KEY, pressed, key});
    endtask

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);  // mid access cycle
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_value({test_name, " pslverr"}, 32'(exp_err), 32'(err));
    endtask

    task automatic read_state();
        logic err;
        repeat (SETTLE) @(posedge clk);
        apb_access(1'b0, REG_SYS, '0, rd_sys, err);
        apb_access(1'b0, REG_P12, '0, rd_p12, err);
        apb_access(1'b0, REG_P34, '0, rd_p34, err);
        apb_access(1'b0, REG_COINS, '0, rd_coins, err);
        -> check_req;
        wait (check_done.triggered);
    endtask

    initial begin : compare_proc
        arcade_ctrl_t exp_ctrl;
        int           exp_coins;
        forever begin
            @(check_req);
            exp_ctrl = expected_controls(exp_coins);
            check_value({test_name, " REG_SYS"},
                        {23'd0, exp_ctrl.pause, exp_ctrl.start, exp_ctrl.coin}, rd_sys);
            check_value({test_name, " REG_P12"}, {16'd0, exp_ctrl.p2, exp_ctrl.p1}, rd_p12);
            check_value({test_name, " REG_P34"}, {16'd0, exp_ctrl.p4, exp_ctrl.p3}, rd_p34);
            check_value({test_name, " REG_COINS"}, 32'(exp_coins), rd_coins);
            -> check_done;
        end
    end

    initial begin : stimulus
        int unsigned seed;
        int          idx;
        logic [31:0] rdata;
        logic        err;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        seed     = 32'ha6e8e9ce;
        void'($urandom(seed));
        wait (!reset);
        @(posedge clk);

        test_name = "make_break";
        for (int k = 0; k < NUM_KEYS; k++) begin
            send_key(KEY_TABLE[k][8:0], 1'b1);
            read_state();
            send_key(KEY_TABLE[k][8:0], 1'b0);
            read_state();
        end

        test_name = "random";
        for (int n = 0; n < 200; n++) begin
            idx = $urandom % NUM_KEYS;
            send_key(KEY_TABLE[idx][8:0], 1'($urandom % 2));
            if (n % 20 == 19) begin
                read_state();
            end
        end

        test_name = "coin_count";
        apb_write(REG_CTRL, 32'h3, 1'b0);  // release all and stay enabled
        event_log.push_back({EV_RELEASE, 10'd0});
        apb_write(REG_COINS, 32'h0, 1'b0);
        event_log.push_back({EV_COIN_CLR, 10'd0});
        send_key(9'h02e, 1'b1);
        send_key(9'h02e, 1'b0);
        send_key(9'h02e, 1'b1);
        send_key(9'h036, 1'b1);
        send_key(9'h03e, 1'b1);
        read_state();
        apb_write(REG_COINS, 32'hffff, 1'b0);
        event_log.push_back({EV_COIN_CLR, 10'd0});
        read_state();

        test_name = "enable";
        apb_write(REG_CTRL, 32'h0, 1'b0);
        event_log.push_back({EV_ENABLE, 1'b0, 9'd0});
        apb_access(1'b0, REG_CTRL, '0, rdata, err);
        check_value("enable REG_CTRL", 32'h0, rdata);
        send_key(9'h175, 1'b1);
        send_key(9'h04d, 1'b1);
        send_key(9'h03e, 1'b0);  // coin 8 stays set while ignored
        read_state();
        apb_write(REG_CTRL, 32'h1, 1'b0);
        event_log.push_back({EV_ENABLE, 1'b1, 9'd0});
        send_key(9'h16b, 1'b1);
        send_key(9'h03e, 1'b0);
        read_state();

        test_name = "release_errors";
        send_key(9'h114, 1'b1);
        send_key(9'h029, 1'b1);
        read_state();
        apb_write(REG_CTRL, 32'h3, 1'b0);
        event_log.push_back({EV_RELEASE, 10'd0});
        apb_access(1'b0, REG_CTRL, '0, rdata, err);
        check_value("release_errors REG_CTRL", 32'h1, rdata);
        read_state();
        ps2_send(8'h1c, 1'b1);  // key a with parity flipped
        read_state();
        apb_access(1'b0, 12'h020, '0, rdata, err);
        check_value("release_errors unmapped pslverr", 32'd1, 32'(err));
        apb_write(REG_SYS, 32'h1, 1'b1);

        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : assertion_watch
        wait (dut.u_assert.fail_count != 0);
        $display("a bound assertion failed, see the error above");
        $display("Some tests failed");
        $fatal(1, "assertion failure");
    end

    initial begin : watchdog
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG);
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== arcade_input.f ====
arcade_input_pkg.sv
ps2_rx.sv
ps2_scancode.sv
arcade_key_map.sv
arcade_input_regs.sv
arcade_input.sv
arcade_input_tb_clk.sv
arcade_input_assert.sv
arcade_input_tb.sv

// ==== Bender.yml ====
package:
  name: arcade_input

sources:
  - arcade_input_pkg.sv
  - ps2_rx.sv
  - ps2_scancode.sv
  - arcade_key_map.sv
  - arcade_input_regs.sv
  - arcade_input.sv
  - target: test
    files:
      - arcade_input_tb_clk.sv
      - arcade_input_assert.sv
      - arcade_input_tb.sv
